/* design/bomb_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants for the bomb game
// Modules import it inside their bodies
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package bomb_pkg;

    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        ARMED    = 3'd1,
        DEFUSED  = 3'd2,
        EXPLODED = 3'd3
    } game_state_e;

    localparam int START_SECONDS  = 30;   // Countdown start
    localparam int TICK_CYCLES    = 1000; // Clocks per game second
    localparam int TICK_W         = $clog2(TICK_CYCLES);
    localparam int TONE_HALF      = 20;   // Alarm half period in clocks
    localparam int TONE_W         = $clog2(TONE_HALF);
    localparam int SSDEC_CYCLES   = 32;   // 16 bits at clk/2
    localparam int TFT_CYCLES     = 16;   // 8 bits at clk/2
    localparam int TFT_RST_CYCLES = 16;   // TFT reset low time after chip reset

    // Entry i sits at bits [2i+1:2i] for the sequence 2 0 3 1
    localparam logic [7:0] DEFUSE_CODE = {2'd1, 2'd3, 2'd0, 2'd2};

    // Segment font with bit 0 = a ... bit 6 = g and bit 7 = dp
    localparam logic [9:0][7:0] SEG_FONT = {
        8'h6F, 8'h7F, 8'h07, 8'h7D, 8'h6D,  // 9 .. 5
        8'h66, 8'h4F, 8'h5B, 8'h06, 8'h3F   // 4 .. 0
    };

    typedef struct packed {
        logic [7:0] tens_seg;  // Sent first
        logic [7:0] ones_seg;
    } ssdec_frame_t;

    typedef struct packed {
        logic        pad;      // Always zero
        game_state_e state;
        logic [3:0]  half_sec; // Seconds / 2 saturated at 15
    } tft_status_t;

    typedef struct packed {
        game_state_e state;
        logic [5:0]  seconds;
        logic        tick;     // One-cycle pulse per countdown step
        logic        changed;  // One-cycle pulse with each state change
    } game_status_t;

endpackage

/* design/button_sync.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Button synchronizer and rising edge detect
// Press pulses only while en is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module button_sync (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic [5:0] button,
    output logic [5:0] press
);

    logic [5:0] sync1;  // Metastability stage
    logic [5:0] sync2;  // Clean level
    logic [5:0] prev;   // Level one cycle earlier

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1 <= '0;
            sync2 <= '0;
            prev  <= '0;
            press <= '0;
        end else begin
            sync1 <= button;
            sync2 <= sync1;
            prev  <= sync2;  // Tracks even while disabled
            // Low to high only
            press <= sync2 & ~prev & {6{en}};
        end
    end

endmodule

/* design/defuse_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game controller for arming, countdown, code entry and outcome
// Buttons 0..3 code, 4 arm, 5 back to idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module defuse_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic [5:0]             press,
    output bomb_pkg::game_status_t status
);
    import bomb_pkg::*;

    game_state_e       state;
    logic [TICK_W-1:0] div_cnt;   // Clocks within current second
    logic [5:0]        seconds;
    logic [1:0]        code_idx;  // Next code entry to match
    logic              tick;
    logic              changed;
    logic              code_hit;
    logic [1:0]        code_btn;
    logic [1:0]        code_want;

    // Lowest pressed code button wins
    always_comb begin
        code_hit = |press[3:0];
        casez (press[3:0])
            4'b???1: code_btn = 2'd0;
            4'b??10: code_btn = 2'd1;
            4'b?100: code_btn = 2'd2;
            default: code_btn = 2'd3;
        endcase
        code_want = DEFUSE_CODE[{code_idx, 1'b0} +: 2];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            div_cnt  <= '0;
            seconds  <= 6'(START_SECONDS);
            code_idx <= '0;
            tick     <= 1'b0;
            changed  <= 1'b0;
        end else begin
            tick    <= 1'b0;  // Pulses by default
            changed <= 1'b0;
            if (en) begin
                if (press[5]) begin
                    if (state != IDLE) begin  // Abort from anywhere
                        state   <= IDLE;
                        seconds <= 6'(START_SECONDS);
                        changed <= 1'b1;
                    end
                end else begin
                    case (state)
                        IDLE: if (press[4]) begin
                            state    <= ARMED;
                            seconds  <= 6'(START_SECONDS);
                            div_cnt  <= '0;
                            code_idx <= '0;
                            changed  <= 1'b1;
                        end
                        ARMED: begin
                            if (div_cnt == TICK_W'(TICK_CYCLES - 1)) begin
                                div_cnt <= '0;
                                seconds <= seconds - 6'd1;
                                tick    <= 1'b1;
                                if (seconds == 6'd1) begin  // Time up
                                    state   <= EXPLODED;
                                    changed <= 1'b1;
                                end
                            end else begin
                                div_cnt <= div_cnt + 1'b1;
                            end
                            // Code entry overrides the timer in the same cycle
                            if (code_hit) begin
                                if (code_btn != code_want) begin
                                    state   <= EXPLODED;
                                    changed <= 1'b1;
                                end else if (code_idx == 2'd3) begin
                                    state   <= DEFUSED;
                                    changed <= 1'b1;
                                end else begin
                                    code_idx <= code_idx + 2'd1;
                                end
                            end
                        end
                        default: ;  // Outcome states wait for button 5
                    endcase
                end
            end
        end
    end

    assign status = '{state: state, seconds: seconds, tick: tick, changed: changed};

endmodule

/* design/ssdec_driver.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Seven-segment serial driver
// 16-bit frame, tens then ones, MSB first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ssdec_driver (
    input  logic                   clk,
    input  logic                   rst_n,
    input  bomb_pkg::game_status_t status,
    output logic                   sdi,
    output logic                   ss,
    output logic                   sck
);
    import bomb_pkg::*;

    logic [3:0]   tens;
    logic [3:0]   ones;
    ssdec_frame_t frame_now;  // Built from live seconds
    ssdec_frame_t shreg;
    logic         req;
    logic         busy;
    logic         pending;    // One request queued behind current frame
    logic [4:0]   cyc;

    always_comb begin
        tens               = 4'(status.seconds / 6'd10);
        ones               = 4'(status.seconds % 6'd10);
        frame_now.tens_seg = SEG_FONT[tens];
        frame_now.ones_seg = SEG_FONT[ones];
    end

    assign req = status.tick | status.changed;
    assign sdi = shreg[$bits(ssdec_frame_t)-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            pending <= 1'b0;
        end else if (!busy) begin
            busy    <= req | pending;  // Start frame
            pending <= 1'b0;
        end else begin
            pending <= pending | req;  // Later requests merge
            if (cyc == 5'(SSDEC_CYCLES - 1)) busy <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ss    <= 1'b1;
            sck   <= 1'b0;
            cyc   <= '0;
            shreg <= '0;
        end else if (!busy) begin
            if (req | pending) begin
                ss    <= 1'b0;
                sck   <= 1'b0;
                cyc   <= '0;
                shreg <= frame_now;  // Data latched at frame start
            end
        end else if (cyc == 5'(SSDEC_CYCLES - 1)) begin
            ss  <= 1'b1;
            sck <= 1'b0;
        end else begin
            cyc <= cyc + 5'd1;
            sck <= ~sck;
            if (sck) shreg <= {shreg[$bits(ssdec_frame_t)-2:0], 1'b0};  // Next bit on falling sck
        end
    end

endmodule

/* design/tft_status.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TFT status link sending one byte per state change
// Also times the TFT reset after chip reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tft_status (
    input  logic                   clk,
    input  logic                   rst_n,
    input  bomb_pkg::game_status_t status,
    output logic                   sck,
    output logic                   sdi,
    output logic                   dc,
    output logic                   rst,
    output logic                   cs
);
    import bomb_pkg::*;

    tft_status_t byte_now;
    tft_status_t shreg;
    logic        busy;
    logic        pending;
    logic [3:0]  cyc;
    logic [4:0]  rst_cnt;

    always_comb begin
        byte_now.pad      = 1'b0;
        byte_now.state    = status.state;
        byte_now.half_sec = (status.seconds[5:1] > 5'd15) ? 4'hF : status.seconds[4:1];
    end

    assign sdi = shreg[$bits(tft_status_t)-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            pending <= 1'b0;
            cs      <= 1'b1;
            dc      <= 1'b0;
            sck     <= 1'b0;
            cyc     <= '0;
            shreg   <= '0;
        end else if (!busy) begin
            pending <= 1'b0;
            if (status.changed | pending) begin
                busy  <= 1'b1;
                cs    <= 1'b0;
                dc    <= 1'b1;      // Data byte
                cyc   <= '0;
                shreg <= byte_now;
            end
        end else begin
            pending <= pending | status.changed;
            if (cyc == 4'(TFT_CYCLES - 1)) begin  // Last high sck phase done
                busy <= 1'b0;
                cs   <= 1'b1;
                dc   <= 1'b0;
                sck  <= 1'b0;
            end else begin
                cyc <= cyc + 4'd1;
                sck <= ~sck;
                if (sck) shreg <= {shreg[$bits(tft_status_t)-2:0], 1'b0};
            end
        end
    end

    // Panel reset held low for a fixed time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_cnt <= '0;
            rst     <= 1'b0;
        end else if (!rst) begin
            rst_cnt <= rst_cnt + 5'd1;
            if (rst_cnt == 5'(TFT_RST_CYCLES - 1)) rst <= 1'b1;
        end
    end

endmodule

/* design/tone_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Alarm square wave while the bomb is exploded
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tone_gen (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  bomb_pkg::game_state_e state,
    output logic                  audio
);
    import bomb_pkg::*;

    logic [TONE_W-1:0] half_cnt;  // Clocks in current half period

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_cnt <= '0;
            audio    <= 1'b0;
        end else if (en && state == EXPLODED) begin
            if (half_cnt == TONE_W'(TONE_HALF - 1)) begin
                half_cnt <= '0;
                audio    <= ~audio;  // Flip every half period
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end else begin
            half_cnt <= '0;  // Silent, restart phase
            audio    <= 1'b0;
        end
    end

endmodule

/* design/bomb_game.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game core from the buttons to the serial links and audio
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module bomb_game (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic [5:0]            button,
    output logic                  ssdec_sdi,
    output logic                  ssdec_ss,
    output logic                  ssdec_sck,
    output logic                  tft_sck,
    output logic                  tft_sdi,
    output logic                  tft_dc,
    output logic                  tft_rst,
    output logic                  tft_cs,
    output bomb_pkg::game_state_e tft_state,
    output logic                  audio
);
    import bomb_pkg::*;

    logic [5:0]   press;   // One-cycle press pulses
    game_status_t status;

    assign tft_state = status.state;

    button_sync u_sync (.clk(clk), .rst_n(rst_n), .en(en), .button(button), .press(press));

    defuse_fsm u_fsm (.clk(clk), .rst_n(rst_n), .en(en), .press(press), .status(status));

    ssdec_driver u_ssdec (
        .clk(clk), .rst_n(rst_n), .status(status),
        .sdi(ssdec_sdi), .ss(ssdec_ss), .sck(ssdec_sck)
    );

    tft_status u_tft (
        .clk(clk), .rst_n(rst_n), .status(status),
        .sck(tft_sck), .sdi(tft_sdi), .dc(tft_dc), .rst(tft_rst), .cs(tft_cs)
    );

    tone_gen u_tone (.clk(clk), .rst_n(rst_n), .en(en), .state(status.state), .audio(audio));

endmodule

/* design/team_07.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chip wrapper for the bomb game
// Buttons on gpio_in[5:0], display, TFT and audio on gpio_out[17:6]
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module team_07 (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         en,          // Game freezes while low

    input  logic [127:0] la_data_in,
    output logic [127:0] la_data_out,
    input  logic [127:0] la_oenb,

    input  logic [33:0]  gpio_in,
    output logic [33:0]  gpio_out,
    output logic [33:0]  gpio_oeb     // Active low
);

    logic [2:0] tft_state;

    assign la_data_out = 128'b0;
    assign gpio_oeb    = 34'h3FFFC003F;  // Pins 6..17 outputs, rest inputs

    // Unused pins held low
    assign gpio_out[33:18] = '0;
    assign gpio_out[5:0]   = '0;
    assign gpio_out[16:14] = tft_state;

    bomb_game game (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .button    (gpio_in[5:0]),  // Raw push buttons
        .ssdec_sdi (gpio_out[6]),
        .ssdec_ss  (gpio_out[7]),
        .ssdec_sck (gpio_out[8]),
        .tft_sck   (gpio_out[9]),
        .tft_sdi   (gpio_out[10]),
        .tft_dc    (gpio_out[11]),
        .tft_rst   (gpio_out[12]),
        .tft_cs    (gpio_out[13]),
        .tft_state (tft_state),
        .audio     (gpio_out[17])
    );

endmodule

/* dv/tb_team_07.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the bomb game chip wrapper
// Decodes both serial links and checks them against a game model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_team_07;
    import bomb_pkg::*;

    localparam int CLK_PERIOD = 40;
    // Countdown run, en-low section and short tests
    localparam int RUN_CYCLES = (START_SECONDS + 7) * TICK_CYCLES + 2000;
    localparam int DOG_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;

    typedef struct packed {
        game_state_e  state;
        logic [5:0]   seconds;
        logic [1:0]   idx;      // Next code entry
        ssdec_frame_t seg;      // Display frame after this step
        tft_status_t  tft;      // Status byte after this step
    } model_t;

    logic         clk;
    logic         rst_n;
    logic         en;
    logic [127:0] la_data_in;
    logic [127:0] la_data_out;
    logic [127:0] la_oenb;
    logic [33:0]  gpio_in;
    logic [33:0]  gpio_out;
    logic [33:0]  gpio_oeb;
    game_state_e  tft_state;

    ssdec_frame_t got_ss[$];    // Captured from the pins
    ssdec_frame_t exp_ss[$];    // From the model
    tft_status_t  got_tft[$];
    tft_status_t  exp_tft[$];
    logic [15:0]  ss_bits;
    logic [7:0]   tft_bits;
    int           ss_cnt = 0;
    int           tft_cnt = 0;
    int           err_cnt = 0;
    model_t       m;

    assign tft_state = game_state_e'(gpio_out[16:14]);

    team_07 UUT (
        .clk(clk), .rst_n(rst_n), .en(en),
        .la_data_in(la_data_in), .la_data_out(la_data_out), .la_oenb(la_oenb),
        .gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oeb(gpio_oeb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run();
        err_cnt++;
        $display("Checks failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_ssdec(input ssdec_frame_t got, input ssdec_frame_t exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: ssdec frame expected %h got %h", $time, exp, got);
            stop_run();
        end
    endtask

    task automatic check_tft(input tft_status_t got, input tft_status_t exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: tft byte expected %h got %h", $time, exp, got);
            stop_run();
        end
    endtask

    task automatic check_state(input game_state_e got, input game_state_e exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: tft_state expected %s got %s",
                     $time, exp.name(), got.name());
            stop_run();
        end
    endtask

    // Pins, words and counts
    task automatic check_pins(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    // Next model state after a press or after one countdown step (btn < 0)
    function automatic model_t model_step(input model_t cur, input int btn);
        model_t nxt;
        nxt = cur;
        if (btn == 5) begin
            if (cur.state != IDLE) begin
                nxt.state   = IDLE;
                nxt.seconds = 6'(START_SECONDS);
            end
        end else if (btn == 4) begin
            if (cur.state == IDLE) begin
                nxt.state   = ARMED;
                nxt.seconds = 6'(START_SECONDS);
                nxt.idx     = 2'd0;
            end
        end else if (cur.state == ARMED) begin
            if (btn < 0) begin
                nxt.seconds = cur.seconds - 6'd1;
                if (cur.seconds == 6'd1)
                    nxt.state = EXPLODED;   // Time up
            end else if (btn != int'(DEFUSE_CODE[2 * cur.idx +: 2])) begin
                nxt.state = EXPLODED;
            end else if (cur.idx == 2'd3) begin
                nxt.state = DEFUSED;
            end else begin
                nxt.idx = cur.idx + 2'd1;
            end
        end
        nxt.seg.tens_seg = SEG_FONT[nxt.seconds / 10];
        nxt.seg.ones_seg = SEG_FONT[nxt.seconds % 10];
        nxt.tft.pad      = 1'b0;
        nxt.tft.state    = nxt.state;
        nxt.tft.half_sec = (nxt.seconds / 2 > 15) ? 4'hF : 4'(nxt.seconds / 2);
        return nxt;
    endfunction

    // Steps the model and queues the frames it implies
    task automatic apply(input int btn);
        model_t nxt;
        nxt = model_step(m, btn);
        if (btn < 0 || nxt.state != m.state)
            exp_ss.push_back(nxt.seg);
        if (nxt.state != m.state)
            exp_tft.push_back(nxt.tft);
        m = nxt;
    endtask

    task automatic press(input int idx);
        @(posedge clk);
        #2 gpio_in[idx] = 1'b1;
        repeat (2) @(posedge clk);
        #2 gpio_in[idx] = 1'b0;
        repeat (6) @(posedge clk);   // Sync, edge detect, FSM update
        apply(idx);
    endtask

    // Wait until all expected frames have been compared
    task automatic drain(input int limit);
        int n;
        n = 0;
        while (exp_ss.size() != 0 || exp_tft.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("Expected serial frame did not arrive within %0d cycles", limit);
                stop_run();
            end
        end
        @(negedge clk);
        check_state(tft_state, m.state);
        check_pins("tft_rst", gpio_out[12], 1'b1);
    endtask

    // Sample the seven-segment link on rising sck while ss is low
    always @(posedge gpio_out[8]) begin
        if (!gpio_out[7]) begin
            ss_bits = {ss_bits[14:0], gpio_out[6]};
            ss_cnt++;
            if (ss_cnt == 16) begin
                got_ss.push_back(ssdec_frame_t'(ss_bits));
                ss_cnt = 0;
            end
        end
    end

    // TFT link sampled the same way while cs is low
    always @(posedge gpio_out[9]) begin
        if (!gpio_out[13]) begin
            check_pins("tft_dc", gpio_out[11], 1'b1);   // Data during frames
            tft_bits = {tft_bits[6:0], gpio_out[10]};
            tft_cnt++;
            if (tft_cnt == 8) begin
                got_tft.push_back(tft_status_t'(tft_bits));
                tft_cnt = 0;
            end
        end
    end

    // Compare captured frames in arrival order
    initial begin
        forever begin
            @(negedge clk);
            while (got_ss.size() != 0) begin
                if (exp_ss.size() == 0) begin
                    $display("Seven-segment frame arrived when none was expected");
                    stop_run();
                end
                check_ssdec(got_ss.pop_front(), exp_ss.pop_front());
            end
            while (got_tft.size() != 0) begin
                if (exp_tft.size() == 0) begin
                    $display("TFT status byte arrived when none was expected");
                    stop_run();
                end
                check_tft(got_tft.pop_front(), exp_tft.pop_front());
            end
        end
    end

    initial begin
        #(DOG_CYCLES * CLK_PERIOD);
        $display("Run did not finish within %0d clock cycles", DOG_CYCLES);
        stop_run();
    end

    initial begin
        int  i;
        int  prefix;
        int  want;
        int  w;
        time t0;
        void'($urandom(32'hbbf6));
        rst_n      = 1'b0;
        en         = 1'b1;
        gpio_in    = '0;
        la_data_in = '0;
        la_oenb    = '0;
        m          = '0;
        m.state    = IDLE;
        m.seconds  = 6'(START_SECONDS);
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        @(negedge clk);

        // Reset values
        check_pins("gpio_oeb", gpio_oeb, 34'h3FFFC003F);
        check_pins("la_data_out", la_data_out, '0);
        check_pins("gpio_out unused", {gpio_out[33:18], gpio_out[5:0]}, '0);
        check_pins("ssdec_ss", gpio_out[7], 1'b1);
        check_pins("ssdec_sck", gpio_out[8], 1'b0);
        check_pins("tft_sck", gpio_out[9], 1'b0);
        check_pins("tft_dc", gpio_out[11], 1'b0);
        check_pins("tft_cs", gpio_out[13], 1'b1);
        check_pins("audio", gpio_out[17], 1'b0);
        check_state(tft_state, IDLE);

        // TFT reset low for its hold time, then high
        check_pins("tft_rst", gpio_out[12], 1'b0);
        repeat (TFT_RST_CYCLES - 1) begin
            @(negedge clk);
            check_pins("tft_rst", gpio_out[12], 1'b0);
        end
        @(negedge clk);
        check_pins("tft_rst", gpio_out[12], 1'b1);

        // Correct code
        press(4);
        drain(200);
        for (i = 0; i < 4; i++)
            press(int'(DEFUSE_CODE[2 * i +: 2]));
        drain(200);
        press(5);           // DEFUSED back to idle
        drain(200);

        // Some right entries, then a wrong one
        press(4);
        drain(200);
        prefix = $urandom % 4;
        for (i = 0; i < prefix; i++)
            press(int'(DEFUSE_CODE[2 * i +: 2]));
        want = int'(DEFUSE_CODE[2 * prefix +: 2]);
        w    = $urandom % 3;
        press((w >= want) ? w + 1 : w);
        drain(200);
        @(posedge gpio_out[17]);
        t0 = $time;
        @(negedge gpio_out[17]);
        check_pins("audio half period", ($time - t0) / CLK_PERIOD, TONE_HALF);
        press(5);
        drain(200);
        check_pins("audio", gpio_out[17], 1'b0);

        // Full countdown
        press(4);
        drain(200);
        repeat (START_SECONDS) apply(-1);
        drain(START_SECONDS * TICK_CYCLES + 200);
        press(5);
        drain(200);

        // Freeze with en low, then resume
        press(4);
        drain(200);
        repeat (2) apply(-1);
        drain(2 * TICK_CYCLES + 200);
        @(posedge clk);
        #2 en = 1'b0;
        repeat (3 * TICK_CYCLES) begin
            @(negedge clk);
            check_state(tft_state, ARMED);
            check_pins("audio", gpio_out[17], 1'b0);
        end
        @(posedge clk);
        #2 en = 1'b1;
        repeat (2) apply(-1);   // Continues from held seconds
        drain(2 * TICK_CYCLES + 200);
        press(5);
        drain(200);

        if (err_cnt == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

/* build.f */
design/bomb_pkg.sv
design/button_sync.sv
design/defuse_fsm.sv
design/ssdec_driver.sv
design/tft_status.sv
design/tone_gen.sv
design/bomb_game.sv
design/team_07.sv
dv/tb_team_07.sv

/* Bender.yml */
package:
  name: team_07

sources:
  - files:
      - design/bomb_pkg.sv
      - design/button_sync.sv
      - design/defuse_fsm.sv
      - design/ssdec_driver.sv
      - design/tft_status.sv
      - design/tone_gen.sv
      - design/bomb_game.sv
      - design/team_07.sv
  - target: test
    files:
      - dv/tb_team_07.sv
